//--- include/issue_defs.svh
// ####################
// Default sizes of the single-warp issue stage
// Rule: DEF_NUM_TAGS must be at least DEF_WB_DEPTH
// ####################
`ifndef ISSUE_DEFS_SVH
`define ISSUE_DEFS_SVH

// Tags in flight and buffer entries
`define DEF_NUM_TAGS  8
`define DEF_WB_DEPTH  4
// Instruction field widths
`define DEF_REG_IDX_W 4
`define DEF_WARP_W    8
`define DEF_PC_W      16
`define DEF_NUM_OPS   2

`endif

//--- hdl/issue_pkg.sv
// ####################
// Shared types of the issue stage
// Struct widths are fixed by the default sizes
// Tag width covers at most DEF_NUM_TAGS tags
// ####################
`include "issue_defs.svh"

package issue_pkg;

    // ####################
    // Constants
    // ####################

    // Source operands per instruction
    localparam int unsigned OP_NUM    = `DEF_NUM_OPS;
    // Register index width
    localparam int unsigned REG_IDX_W = `DEF_REG_IDX_W;
    // Tag width from the default tag count
    localparam int unsigned TAG_W     = $clog2(`DEF_NUM_TAGS);
    localparam int unsigned PC_W      = `DEF_PC_W;
    localparam int unsigned WARP_W    = `DEF_WARP_W;

    // ####################
    // Types
    // ####################

    // Opcodes pass through the issue stage untouched
    typedef enum logic [3:0] {
        OP_ADD = 4'd0,
        OP_SUB = 4'd1,
        OP_MUL = 4'd2,
        OP_LD  = 4'd3,
        OP_ST  = 4'd4,
        OP_MOV = 4'd5
    } opcode_e;

    typedef logic [TAG_W-1:0]     tag_t;
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Decoded instruction, 42 bits
    typedef struct packed {
        logic [PC_W-1:0]             pc;
        logic [WARP_W-1:0]           act_mask;
        opcode_e                     opcode;
        reg_idx_t                    dst;
        logic [OP_NUM-1:0]           ops_req;
        reg_idx_t [OP_NUM-1:0]       ops;
    } dec_inst_t;

    // Instruction towards the operand collector, 45 bits
    typedef struct packed {
        dec_inst_t inst;
        tag_t      tag;
    } disp_inst_t;

endpackage

//--- hdl/tag_pool.sv
// ####################
// Circular free list of tags, full after reset
// Pushes only tags that were popped before
// NumTags must not exceed the range of tag_t
// ####################
`timescale 1ns/1ns

module tag_pool import issue_pkg::*; #(
    parameter int unsigned NumTags = 8
) (
    input  logic clk_i,
    input  logic arst_n_i,
    // Pop side
    input  logic get_i,
    output tag_t tag_o,
    output logic avail_o,
    // Push side, completed tags
    input  logic free_i,
    input  tag_t free_tag_i
);

    localparam int unsigned PtrW = NumTags > 1 ? $clog2(NumTags) : 1;
    localparam int unsigned CntW = $clog2(NumTags + 1);

    tag_t            mem_q [NumTags];
    logic [PtrW-1:0] rd_ptr_q;
    logic [PtrW-1:0] wr_ptr_q;
    logic [CntW-1:0] count_q;
    logic            pop;

    // Head of the list is the next tag to hand out
    assign tag_o   = mem_q[rd_ptr_q];
    assign avail_o = count_q != '0;
    assign pop     = get_i && avail_o;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // Every tag free, ascending order
            for (int i = 0; i < NumTags; i++) begin
                mem_q[i] <= tag_t'(i);
            end
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= CntW'(NumTags);
        end else begin
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PtrW'(NumTags - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (free_i) begin
                mem_q[wr_ptr_q] <= free_tag_i;
                wr_ptr_q <= (wr_ptr_q == PtrW'(NumTags - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            // Push and pop together leave the count unchanged
            case ({pop, free_i})
                2'b10:   count_q <= count_q - 1'b1;
                2'b01:   count_q <= count_q + 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

endmodule

//--- hdl/scoreboard.sv
// ####################
// Producer tag per register for the single warp
// Lookup sees completions of the same cycle
// Write of a new producer happens on the edge after lookup
// ####################
`timescale 1ns/1ns

module scoreboard import issue_pkg::*; (
    input  logic                  clk_i,
    input  logic                  arst_n_i,
    // New instruction
    input  logic                  accept_i,
    input  reg_idx_t              dst_i,
    input  tag_t                  tag_i,
    input  reg_idx_t [OP_NUM-1:0] ops_i,
    output logic [OP_NUM-1:0]     ops_ready_o,
    output tag_t [OP_NUM-1:0]     ops_tag_o,
    // Completion strobe
    input  logic                  eu_valid_i,
    input  tag_t                  eu_tag_i
);

    localparam int unsigned NumRegs = 2 ** REG_IDX_W;

    logic [NumRegs-1:0] busy_q;
    tag_t               prod_tag_q [NumRegs];

    // ####################
    // Lookup
    // ####################

    always_comb begin
        for (int k = 0; k < OP_NUM; k++) begin
            ops_tag_o[k]   = prod_tag_q[ops_i[k]];
            // Ready when idle or when its producer finishes right now
            ops_ready_o[k] = !busy_q[ops_i[k]]
                          || (eu_valid_i && (eu_tag_i == prod_tag_q[ops_i[k]]));
        end
    end

    // ####################
    // Update
    // ####################

    // Busy bits
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            busy_q <= '0;
        end else begin
            for (int r = 0; r < NumRegs; r++) begin
                if (accept_i && (dst_i == reg_idx_t'(r))) begin
                    // New producer wins over a clear
                    busy_q[r] <= 1'b1;
                end else if (eu_valid_i && busy_q[r] && (prod_tag_q[r] == eu_tag_i)) begin
                    // Only the latest producer may clear
                    busy_q[r] <= 1'b0;
                end
            end
        end
    end

    // Producer tags, only meaningful while busy
    always_ff @(posedge clk_i) begin
        if (accept_i) begin
            prod_tag_q[dst_i] <= tag_i;
        end
    end

endmodule

//--- hdl/wait_buffer.sv
// ####################
// Instructions wait here until all operands are ready
// Oldest ready entry is shown, held under back-pressure
// Entry tags must be unique, as given by the tag pool
// ####################
`timescale 1ns/1ns

module wait_buffer import issue_pkg::*; #(
    parameter int unsigned WbDepth = 4
) (
    input  logic                              clk_i,
    input  logic                              arst_n_i,
    // Insert side
    input  logic                              accept_i,
    input  dec_inst_t                         inst_i,
    input  tag_t                              tag_i,
    input  logic [OP_NUM-1:0]                 ops_ready_i,
    input  tag_t [OP_NUM-1:0]                 ops_tag_i,
    output logic                              free_o,
    output logic [$clog2(WbDepth + 1)-1:0]    count_o,
    // Wakeup
    input  logic                              eu_valid_i,
    input  tag_t                              eu_tag_i,
    // Towards the operand collector
    input  logic                              opc_ready_i,
    output logic                              disp_valid_o,
    output disp_inst_t                        disp_inst_o
);

    localparam int unsigned IdxW = WbDepth > 1 ? $clog2(WbDepth) : 1;
    localparam int unsigned CntW = $clog2(WbDepth + 1);
    // Twice the depth so that live sequence numbers never alias
    localparam int unsigned SeqW = IdxW + 1;

    typedef struct packed {
        disp_inst_t        inst;
        logic [OP_NUM-1:0] op_rdy;
        tag_t [OP_NUM-1:0] op_tag;
        logic [SeqW-1:0]   seq;
    } wb_entry_t;

    wb_entry_t          ent_q [WbDepth];
    wb_entry_t          new_ent;
    logic [WbDepth-1:0] valid_q;
    logic [SeqW-1:0]    seq_q;
    logic [IdxW-1:0]    ins_idx;
    logic [IdxW-1:0]    best_idx;
    logic [IdxW-1:0]    sel_idx;
    logic [IdxW-1:0]    hold_idx_q;
    logic               best_found;
    logic               hold_q;
    logic               dispatch;

    // True when sequence a was inserted before b
    function automatic logic older(input logic [SeqW-1:0] a, input logic [SeqW-1:0] b);
        logic [SeqW-1:0] diff;
        diff = a - b;
        return diff[SeqW-1];
    endfunction

    // ####################
    // Insert
    // ####################

    always_comb begin
        new_ent.inst.inst = inst_i;
        new_ent.inst.tag  = tag_i;
        // Operands that are not needed count as ready
        new_ent.op_rdy    = ops_ready_i | ~inst_i.ops_req;
        new_ent.op_tag    = ops_tag_i;
        new_ent.seq       = seq_q;
    end

    // Lowest free slot
    always_comb begin
        ins_idx = '0;
        for (int i = WbDepth - 1; i >= 0; i--) begin
            if (!valid_q[i]) begin
                ins_idx = IdxW'(i);
            end
        end
    end

    assign free_o = ~&valid_q;

    always_comb begin
        count_o = '0;
        for (int i = 0; i < WbDepth; i++) begin
            count_o = count_o + CntW'(valid_q[i]);
        end
    end

    // ####################
    // Selection
    // ####################

    // Oldest entry with every operand ready
    always_comb begin
        best_found = 1'b0;
        best_idx   = '0;
        for (int i = 0; i < WbDepth; i++) begin
            if (valid_q[i] && (&ent_q[i].op_rdy)
                    && (!best_found || older(ent_q[i].seq, ent_q[best_idx].seq))) begin
                best_found = 1'b1;
                best_idx   = IdxW'(i);
            end
        end
    end

    // A stalled entry stays shown even if an older one wakes up
    assign sel_idx      = hold_q ? hold_idx_q : best_idx;
    assign disp_valid_o = hold_q || best_found;
    assign disp_inst_o  = ent_q[sel_idx].inst;
    assign dispatch     = disp_valid_o && opc_ready_i;

    // ####################
    // State
    // ####################

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            valid_q    <= '0;
            seq_q      <= '0;
            hold_q     <= 1'b0;
            hold_idx_q <= '0;
        end else begin
            hold_q     <= disp_valid_o && !opc_ready_i;
            hold_idx_q <= sel_idx;
            // Insert goes to a free slot, dispatch frees a full one
            if (accept_i) begin
                valid_q[ins_idx] <= 1'b1;
                seq_q            <= seq_q + 1'b1;
            end
            if (dispatch) begin
                valid_q[sel_idx] <= 1'b0;
            end
        end
    end

    // Entry payload and wakeup
    always_ff @(posedge clk_i) begin
        for (int j = 0; j < WbDepth; j++) begin
            for (int k = 0; k < OP_NUM; k++) begin
                if (eu_valid_i && (ent_q[j].op_tag[k] == eu_tag_i)) begin
                    ent_q[j].op_rdy[k] <= 1'b1;
                end
            end
        end
        // Lookup already folded in this cycle's completion
        if (accept_i) begin
            ent_q[ins_idx] <= new_ent;
        end
    end

endmodule

//--- hdl/issue_ctrl.sv
// ####################
// Accept decision and slot accounting
// Control instructions release a fetch slot without entering the buffer
// ####################
`timescale 1ns/1ns

module issue_ctrl #(
    parameter int unsigned NumTags = 8,
    parameter int unsigned WbDepth = 4
) (
    input  logic                           clk_i,
    input  logic                           arst_n_i,
    input  logic                           dec_valid_i,
    // Datapath status
    input  logic                           tag_avail_i,
    input  logic                           wb_free_i,
    input  logic [$clog2(WbDepth + 1)-1:0] wb_count_i,
    // Strobes
    input  logic                           fe_handshake_i,
    input  logic                           dec_control_decoded_i,
    input  logic                           eu_valid_i,
    // Outputs
    output logic                           dec_ready_o,
    output logic                           accept_o,
    output logic                           ib_space_o,
    output logic                           all_done_o
);

    localparam int unsigned FlyW = $clog2(NumTags + 1);
    // One spare bit for fetches ahead of the buffer
    localparam int unsigned RsvW = $clog2(WbDepth + 1) + 1;

    logic [FlyW-1:0] inflight_q;
    logic [RsvW-1:0] rsv_q;
    logic [RsvW-1:0] rsv_inc;
    logic [1:0]      rsv_rel;

    // ####################
    // Accept
    // ####################

    assign dec_ready_o = tag_avail_i && wb_free_i && (inflight_q < FlyW'(NumTags));
    assign accept_o    = dec_valid_i && dec_ready_o;

    // ####################
    // Counters
    // ####################

    // Reserved slots, released on accept or on a control instruction
    assign rsv_rel = {1'b0, accept_o} + {1'b0, dec_control_decoded_i};
    assign rsv_inc = rsv_q + RsvW'(fe_handshake_i);

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsv_q      <= '0;
            inflight_q <= '0;
        end else begin
            rsv_q <= (rsv_inc >= RsvW'(rsv_rel)) ? rsv_inc - RsvW'(rsv_rel) : '0;
            // Issue and completion may cancel out
            case ({accept_o, eu_valid_i})
                2'b10:   inflight_q <= inflight_q + 1'b1;
                2'b01:   inflight_q <= inflight_q - 1'b1;
                default: inflight_q <= inflight_q;
            endcase
        end
    end

    // ####################
    // Status
    // ####################

    assign ib_space_o = (32'(rsv_q) + 32'(wb_count_i)) < WbDepth;
    assign all_done_o = inflight_q == '0;

endmodule

//--- hdl/issue_top.sv
// ####################
// Issue stage of a single-warp SIMT core
// NumTags must be at least WbDepth and fit in tag_t
// ####################
`timescale 1ns/1ns
`include "issue_defs.svh"

module issue_top import issue_pkg::*; #(
    parameter int unsigned NumTags = `DEF_NUM_TAGS,
    parameter int unsigned WbDepth = `DEF_WB_DEPTH
) (
    input  logic       clk_i,
    input  logic       arst_n_i,
    // Fetch accounting
    input  logic       fe_handshake_i,
    input  logic       dec_control_decoded_i,
    // Decoder
    input  logic       dec_valid_i,
    input  dec_inst_t  dec_inst_i,
    output logic       dec_ready_o,
    // Operand collector
    input  logic       opc_ready_i,
    output logic       disp_valid_o,
    output disp_inst_t disp_inst_o,
    // Execution units
    input  logic       eu_valid_i,
    input  tag_t       eu_tag_i,
    // Status
    output logic       ib_space_o,
    output logic       all_done_o
);

    logic                           accept;
    logic                           tag_avail;
    tag_t                           new_tag;
    logic [OP_NUM-1:0]              ops_ready;
    tag_t [OP_NUM-1:0]              ops_tag;
    logic                           wb_free;
    logic [$clog2(WbDepth + 1)-1:0] wb_count;

    // ####################
    // Control
    // ####################

    issue_ctrl #(.NumTags(NumTags), .WbDepth(WbDepth)) i_ctrl (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .dec_valid_i(dec_valid_i),
        .tag_avail_i(tag_avail), .wb_free_i(wb_free), .wb_count_i(wb_count),
        .fe_handshake_i(fe_handshake_i), .dec_control_decoded_i(dec_control_decoded_i),
        .eu_valid_i(eu_valid_i), .dec_ready_o(dec_ready_o), .accept_o(accept),
        .ib_space_o(ib_space_o), .all_done_o(all_done_o)
    );

    // ####################
    // Datapath
    // ####################

    // Tags return to the pool on completion
    tag_pool #(.NumTags(NumTags)) i_tag_pool (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .get_i(accept), .tag_o(new_tag),
        .avail_o(tag_avail), .free_i(eu_valid_i), .free_tag_i(eu_tag_i)
    );

    scoreboard i_scoreboard (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .accept_i(accept), .dst_i(dec_inst_i.dst),
        .tag_i(new_tag), .ops_i(dec_inst_i.ops), .ops_ready_o(ops_ready),
        .ops_tag_o(ops_tag), .eu_valid_i(eu_valid_i), .eu_tag_i(eu_tag_i)
    );

    wait_buffer #(.WbDepth(WbDepth)) i_wait_buffer (
        .clk_i(clk_i), .arst_n_i(arst_n_i), .accept_i(accept), .inst_i(dec_inst_i),
        .tag_i(new_tag), .ops_ready_i(ops_ready), .ops_tag_i(ops_tag),
        .free_o(wb_free), .count_o(wb_count), .eu_valid_i(eu_valid_i),
        .eu_tag_i(eu_tag_i), .opc_ready_i(opc_ready_i), .disp_valid_o(disp_valid_o),
        .disp_inst_o(disp_inst_o)
    );

endmodule

//--- dv/tb_clk_gen.sv
// ####################
// Free-running testbench clock and power-on reset
// Reset releases shortly after the last reset edge
// ####################
`timescale 1ns/1ns

module tb_clk_gen #(
    parameter int PeriodNs  = 40,
    parameter int RstCycles = 8
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PeriodNs / 2) clk_o = ~clk_o;
        end
    end

    // Low for RstCycles rising edges
    initial begin
        arst_n_o = 1'b0;
        repeat (RstCycles) @(posedge clk_o);
        #2 arst_n_o = 1'b1;
    end

endmodule

//--- dv/tb_issue.sv
// ####################
// Random testbench of the issue stage against a reference model
// Fetch, decoder, collector and execution units are modeled here
// Only eight registers are used so that hazards are frequent
// ####################
`timescale 1ns/1ns

module tb_issue import issue_pkg::*; ();

    localparam int          NumTags     = 8;
    localparam int          WbDepth     = 4;
    localparam int          RstCycles   = 8;
    localparam int          NumCycles   = 2000;
    localparam int          DrainCycles = 200;
    localparam int          MaxInst     = 4096;
    localparam time         DriveDelay  = 2;
    localparam logic [31:0] Seed        = 32'h5f16;

    logic       clk;
    logic       arst_n;
    logic       fe_handshake;
    logic       dec_control_decoded;
    logic       dec_valid;
    dec_inst_t  dec_inst;
    logic       dec_ready;
    logic       opc_ready;
    logic       disp_valid;
    disp_inst_t disp_inst;
    logic       eu_valid;
    tag_t       eu_tag;
    logic       ib_space;
    logic       all_done;

    // ####################
    // Model state
    // ####################

    logic [31:0] lfsr_q;
    int          cyc;
    int          n_acc;
    int          n_disp;
    int          rsv;
    int          wb_cnt;
    int          inflight;
    int          eu_id;
    logic        stall_prev;
    disp_inst_t  disp_prev;
    // Per accepted instruction, indexed by accept order
    dec_inst_t   rec_inst [MaxInst];
    tag_t        rec_tag [MaxInst];
    int          rec_dep [MaxInst][OP_NUM];
    logic        rec_done [MaxInst];
    // Last writer of each register, -1 when never written
    int          last_wr [2 ** REG_IDX_W];
    tag_t        free_q [$];
    int          wait_q [$];
    int          pend_id [$];
    int          pend_due [$];

    tb_clk_gen #(.PeriodNs(40), .RstCycles(RstCycles)) i_clk_gen (
        .clk_o(clk), .arst_n_o(arst_n)
    );

    issue_top #(.NumTags(NumTags), .WbDepth(WbDepth)) i_dut (
        .clk_i(clk), .arst_n_i(arst_n), .fe_handshake_i(fe_handshake),
        .dec_control_decoded_i(dec_control_decoded), .dec_valid_i(dec_valid),
        .dec_inst_i(dec_inst), .dec_ready_o(dec_ready), .opc_ready_i(opc_ready),
        .disp_valid_o(disp_valid), .disp_inst_o(disp_inst), .eu_valid_i(eu_valid),
        .eu_tag_i(eu_tag), .ib_space_o(ib_space), .all_done_o(all_done)
    );

    // ####################
    // Helpers
    // ####################

    // Galois LFSR, taps of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        logic lsb;
        lsb = s[0];
        s   = s >> 1;
        if (lsb) begin
            s = s ^ 32'h8020_0003;
        end
        return s;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] val;
        val = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            val    = {val[30:0], lfsr_q[0]};
        end
        return val;
    endfunction

    task automatic abort_run();
        $display("TEST RESULT: FAIL");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_error(input string what);
        $display("Error in cycle %0d: %s", cyc, what);
        abort_run();
    endtask

    task automatic check_eq(input string name, input logic [63:0] exp, input logic [63:0] act);
        if (act !== exp) begin
            $display("[FAIL] %s: expected 0x%0h, actual 0x%0h in cycle %0d", name, exp, act, cyc);
            abort_run();
        end
    endtask

    // Outputs of an empty, idle issue stage
    task automatic check_idle();
        check_eq("disp_valid_o", 64'(0), 64'(disp_valid));
        check_eq("dec_ready_o", 64'(1), 64'(dec_ready));
        check_eq("ib_space_o", 64'(1), 64'(ib_space));
        check_eq("all_done_o", 64'(1), 64'(all_done));
    endtask

    // ####################
    // Stimulus
    // ####################

    task automatic drive_inputs(input bit stim);
        int         idx;
        logic [1:0] pick;
        // Oldest completion that is due, at most one per cycle
        idx = -1;
        for (int i = pend_id.size() - 1; i >= 0; i--) begin
            if (pend_due[i] <= cyc) begin
                idx = i;
            end
        end
        eu_valid = 1'b0;
        eu_tag   = '0;
        eu_id    = -1;
        if (idx >= 0) begin
            eu_id    = pend_id[idx];
            eu_valid = 1'b1;
            eu_tag   = rec_tag[eu_id];
            pend_id.delete(idx);
            pend_due.delete(idx);
        end
        // Collector stalls one cycle in four
        opc_ready = rand_bits(2) != 0;
        // Fetcher only takes an instruction while there is room
        pick         = 2'(rand_bits(1));
        fe_handshake = stim && (rsv + wb_cnt < WbDepth) && pick[0];
        // Decoder works on fetched instructions only
        dec_valid           = 1'b0;
        dec_control_decoded = 1'b0;
        if (stim && rsv > 0) begin
            pick = 2'(rand_bits(2));
            if (pick == 2'd0) begin
                dec_control_decoded = 1'b1;
            end else begin
                dec_valid = 1'b1;
            end
        end
        dec_inst.pc       = 16'(rand_bits(16));
        dec_inst.act_mask = 8'(rand_bits(8));
        dec_inst.opcode   = opcode_e'(4'(rand_bits(3) % 6));
        dec_inst.dst      = reg_idx_t'(rand_bits(3));
        dec_inst.ops_req  = OP_NUM'(rand_bits(OP_NUM));
        for (int k = 0; k < OP_NUM; k++) begin
            dec_inst.ops[k] = reg_idx_t'(rand_bits(3));
        end
    endtask

    // ####################
    // Checks and model update
    // ####################

    task automatic sample_cycle();
        int idx;
        int id;
        int same;
        check_eq("all_done_o", 64'(inflight == 0), 64'(all_done));
        check_eq("ib_space_o", 64'(rsv + wb_cnt < WbDepth), 64'(ib_space));
        // Refused while the buffer is full or every tag is out
        check_eq("dec_ready_o", 64'(wb_cnt < WbDepth && inflight < NumTags), 64'(dec_ready));
        // Stalled output must hold
        if (stall_prev) begin
            check_eq("disp_valid_o", 64'(1), 64'(disp_valid));
            check_eq("disp_inst_o", 64'(disp_prev), 64'(disp_inst));
        end
        // Dispatch, matched by tag
        if (disp_valid && opc_ready) begin
            // Tags still out at the execution units are not free for reuse
            same = 0;
            foreach (pend_id[i]) begin
                if (rec_tag[pend_id[i]] == disp_inst.tag) begin
                    same++;
                end
            end
            if (eu_valid && rec_tag[eu_id] == disp_inst.tag) begin
                same++;
            end
            if (same != 0) begin
                report_error("dispatched tag is held by another instruction in flight");
            end
            idx = -1;
            foreach (wait_q[i]) begin
                if (rec_tag[wait_q[i]] == disp_inst.tag) begin
                    idx = i;
                end
            end
            if (idx < 0) begin
                report_error("dispatched tag belongs to no waiting instruction");
            end
            id = wait_q[idx];
            check_eq("disp_inst_o.inst.pc", 64'(rec_inst[id].pc), 64'(disp_inst.inst.pc));
            check_eq("disp_inst_o.inst.act_mask", 64'(rec_inst[id].act_mask),
                     64'(disp_inst.inst.act_mask));
            check_eq("disp_inst_o.inst.opcode", 64'(rec_inst[id].opcode),
                     64'(disp_inst.inst.opcode));
            check_eq("disp_inst_o.inst.dst", 64'(rec_inst[id].dst), 64'(disp_inst.inst.dst));
            check_eq("disp_inst_o.inst.ops_req", 64'(rec_inst[id].ops_req),
                     64'(disp_inst.inst.ops_req));
            check_eq("disp_inst_o.inst.ops", 64'(rec_inst[id].ops), 64'(disp_inst.inst.ops));
            // Producers must have finished in an earlier cycle
            for (int k = 0; k < OP_NUM; k++) begin
                if (rec_dep[id][k] >= 0 && !rec_done[rec_dep[id][k]]) begin
                    report_error($sformatf("instruction %0d dispatched before producer %0d",
                                           id, rec_dep[id][k]));
                end
            end
            wait_q.delete(idx);
            wb_cnt--;
            n_disp++;
            // Execution latency of 1 to 6 cycles
            pend_id.push_back(id);
            pend_due.push_back(cyc + 1 + int'(rand_bits(3) % 6));
        end
        // Accept, sources looked up before dst is claimed
        if (dec_valid && dec_ready) begin
            id = n_acc;
            n_acc++;
            rec_inst[id] = dec_inst;
            rec_tag[id]  = free_q.pop_front();
            rec_done[id] = 1'b0;
            for (int k = 0; k < OP_NUM; k++) begin
                rec_dep[id][k] = dec_inst.ops_req[k] ? last_wr[dec_inst.ops[k]] : -1;
            end
            last_wr[dec_inst.dst] = id;
            wait_q.push_back(id);
            wb_cnt++;
            inflight++;
            rsv--;
        end
        // Completion returns the tag after any pop of this cycle
        if (eu_valid) begin
            rec_done[eu_id] = 1'b1;
            free_q.push_back(rec_tag[eu_id]);
            inflight--;
        end
        if (dec_control_decoded) begin
            rsv--;
        end
        if (fe_handshake) begin
            rsv++;
        end
        stall_prev = disp_valid && !opc_ready;
        disp_prev  = disp_inst;
    endtask

    // Drive after the rising edge, sample at the falling edge
    task automatic run_cycle(input bit stim);
        @(posedge clk);
        #DriveDelay;
        cyc++;
        drive_inputs(stim);
        @(negedge clk);
        sample_cycle();
    endtask

    // ####################
    // Main sequence
    // ####################

    initial begin
        lfsr_q              = Seed;
        cyc                 = 0;
        n_acc               = 0;
        n_disp              = 0;
        rsv                 = 0;
        wb_cnt              = 0;
        inflight            = 0;
        eu_id               = -1;
        stall_prev          = 1'b0;
        disp_prev           = '0;
        fe_handshake        = 1'b0;
        dec_control_decoded = 1'b0;
        dec_valid           = 1'b0;
        dec_inst            = '0;
        opc_ready           = 1'b0;
        eu_valid            = 1'b0;
        eu_tag              = '0;
        foreach (last_wr[r]) begin
            last_wr[r] = -1;
        end
        for (int t = 0; t < NumTags; t++) begin
            free_q.push_back(tag_t'(t));
        end
        // Idle while reset is held and right after release
        repeat (RstCycles - 1) begin
            @(negedge clk);
            check_idle();
        end
        wait (arst_n === 1'b1);
        @(negedge clk);
        check_idle();
        for (int c = 0; c < NumCycles; c++) begin
            run_cycle(1'b1);
        end
        // Drain without new work
        while (wait_q.size() != 0 || pend_id.size() != 0 || inflight != 0) begin
            run_cycle(1'b0);
        end
        run_cycle(1'b0);
        check_eq("disp_valid_o", 64'(0), 64'(disp_valid));
        if (n_disp != n_acc) begin
            report_error($sformatf("%0d accepted but %0d dispatched", n_acc, n_disp));
        end else begin
            $display("TEST RESULT: PASS");
            $finish;
        end
    end

    // Watchdog over reset, stimulus and drain
    initial begin
        repeat (RstCycles + NumCycles + DrainCycles) @(posedge clk);
        report_error("watchdog expired before the run drained");
    end

endmodule

//--- vlog.f
+incdir+include
hdl/issue_pkg.sv
hdl/tag_pool.sv
hdl/scoreboard.sv
hdl/wait_buffer.sv
hdl/issue_ctrl.sv
hdl/issue_top.sv
dv/tb_clk_gen.sv
dv/tb_issue.sv
